// ==== design/rv_pkg.sv ====
// Shared types and constants for the single-cycle RV32I core
// Only the RV32I base integer set is encoded; no CSR or system opcodes
`default_nettype none

package rv_pkg;

  typedef logic [31:0] xlen_t;

  localparam xlen_t RESET_PC = 32'h0000_0000;
  localparam int NUM_REGS = 32;

  // --------------------------------------------------
  // Major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_t;

  // --------------------------------------------------
  // ALU functions; compares give 1 when a branch is taken
  typedef enum logic [4:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_SLL    = 5'd2,
    ALU_SLT    = 5'd3,
    ALU_SLTU   = 5'd4,
    ALU_XOR    = 5'd5,
    ALU_SRL    = 5'd6,
    ALU_SRA    = 5'd7,
    ALU_OR     = 5'd8,
    ALU_AND    = 5'd9,
    ALU_SEQ    = 5'd10,
    ALU_SNE    = 5'd11,
    ALU_SGE    = 5'd12,
    ALU_SGEU   = 5'd13,
    ALU_PASS_B = 5'd14
  } alu_fn_t;

  typedef enum logic [2:0] {
    WB_ALU       = 3'd0,
    WB_MEM       = 3'd1,
    WB_PC_PLUS_4 = 3'd2,
    WB_IMM       = 3'd3
  } wb_sel_t;

  // Aligned ALU result is the jalr target
  typedef enum logic [1:0] {
    NPC_PC_PLUS_4   = 2'd0,
    NPC_PC_PLUS_IMM = 2'd1,
    NPC_ALU_ALIGNED = 2'd2
  } next_pc_sel_t;

endpackage

`default_nettype wire

// ==== design/ctl_if.sv ====
// Control decisions from the control path into the datapath
// All signals are combinational within the current instruction cycle
`default_nettype none

interface ctl_if;

  rv_pkg::alu_fn_t      alu_function;
  logic                 alu_operand_a_select;  // 0 rs1, 1 pc
  logic                 alu_operand_b_select;  // 0 rs2, 1 immediate
  rv_pkg::wb_sel_t      reg_writeback_select;
  rv_pkg::next_pc_sel_t next_pc_select;
  logic                 regfile_write_enable;
  logic                 pc_write_enable;

  modport ctl (
    output alu_function, alu_operand_a_select, alu_operand_b_select,
           reg_writeback_select, next_pc_select, regfile_write_enable,
           pc_write_enable
  );

  modport dp (
    input alu_function, alu_operand_a_select, alu_operand_b_select,
          reg_writeback_select, next_pc_select, regfile_write_enable,
          pc_write_enable
  );

endinterface

`default_nettype wire

// ==== design/singlecycle_ctlpath.sv ====
// Combinational decoder for the single-cycle core
// Unknown opcodes fall through as no-ops that advance pc by 4
// All write and bus enables are held low while rst is high
`default_nettype none

module singlecycle_ctlpath (
  input  logic       rst,
  input  logic [6:0] inst_opcode,
  input  logic [2:0] inst_funct3,
  input  logic [6:0] inst_funct7,
  input  logic       alu_result_equal_zero,
  ctl_if.ctl         ctl,
  output logic       data_mem_read_enable,
  output logic       data_mem_write_enable
);

  rv_pkg::alu_fn_t arith_function;
  rv_pkg::alu_fn_t branch_function;

  // --------------------------------------------------
  // ALU function for OP and OP_IMM
  always_comb begin
    case (inst_funct3)
      3'b000: begin
        // Only register-register form has sub
        if (inst_opcode == rv_pkg::OP && inst_funct7[5]) begin
          arith_function = rv_pkg::ALU_SUB;
        end else begin
          arith_function = rv_pkg::ALU_ADD;
        end
      end
      3'b001: arith_function = rv_pkg::ALU_SLL;
      3'b010: arith_function = rv_pkg::ALU_SLT;
      3'b011: arith_function = rv_pkg::ALU_SLTU;
      3'b100: arith_function = rv_pkg::ALU_XOR;
      3'b101: arith_function = inst_funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110: arith_function = rv_pkg::ALU_OR;
      default: arith_function = rv_pkg::ALU_AND;
    endcase
  end

  // Branch compare where a nonzero result means taken
  always_comb begin
    case (inst_funct3)
      3'b000:  branch_function = rv_pkg::ALU_SEQ;
      3'b001:  branch_function = rv_pkg::ALU_SNE;
      3'b100:  branch_function = rv_pkg::ALU_SLT;
      3'b101:  branch_function = rv_pkg::ALU_SGE;
      3'b110:  branch_function = rv_pkg::ALU_SLTU;
      default: branch_function = rv_pkg::ALU_SGEU;
    endcase
  end

  // --------------------------------------------------
  // Main decode
  always_comb begin
    ctl.alu_function         = rv_pkg::ALU_ADD;
    ctl.alu_operand_a_select = 1'b0;
    ctl.alu_operand_b_select = 1'b1;
    ctl.reg_writeback_select = rv_pkg::WB_ALU;
    ctl.next_pc_select       = rv_pkg::NPC_PC_PLUS_4;
    ctl.regfile_write_enable = 1'b0;
    ctl.pc_write_enable      = 1'b1;
    data_mem_read_enable     = 1'b0;
    data_mem_write_enable    = 1'b0;

    case (inst_opcode)
      rv_pkg::OP: begin
        ctl.alu_function         = arith_function;
        ctl.alu_operand_b_select = 1'b0;
        ctl.regfile_write_enable = 1'b1;
      end
      rv_pkg::OP_IMM: begin
        ctl.alu_function         = arith_function;
        ctl.regfile_write_enable = 1'b1;
      end
      rv_pkg::LOAD: begin
        ctl.reg_writeback_select = rv_pkg::WB_MEM;
        ctl.regfile_write_enable = 1'b1;
        data_mem_read_enable     = 1'b1;
      end
      rv_pkg::STORE: begin
        data_mem_write_enable = 1'b1;
      end
      rv_pkg::BRANCH: begin
        ctl.alu_function         = branch_function;
        ctl.alu_operand_b_select = 1'b0;
        if (!alu_result_equal_zero) begin
          ctl.next_pc_select = rv_pkg::NPC_PC_PLUS_IMM;
        end
      end
      rv_pkg::JAL: begin
        ctl.alu_operand_a_select = 1'b1;
        ctl.reg_writeback_select = rv_pkg::WB_PC_PLUS_4;
        ctl.next_pc_select       = rv_pkg::NPC_PC_PLUS_IMM;
        ctl.regfile_write_enable = 1'b1;
      end
      rv_pkg::JALR: begin
        ctl.reg_writeback_select = rv_pkg::WB_PC_PLUS_4;
        ctl.next_pc_select       = rv_pkg::NPC_ALU_ALIGNED;
        ctl.regfile_write_enable = 1'b1;
      end
      rv_pkg::LUI: begin
        ctl.alu_function         = rv_pkg::ALU_PASS_B;
        ctl.regfile_write_enable = 1'b1;
      end
      rv_pkg::AUIPC: begin
        ctl.alu_operand_a_select = 1'b1;
        ctl.regfile_write_enable = 1'b1;
      end
      default: begin
      end
    endcase

    if (rst) begin
      ctl.regfile_write_enable = 1'b0;
      ctl.pc_write_enable      = 1'b0;
      data_mem_read_enable     = 1'b0;
      data_mem_write_enable    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/singlecycle_datapath.sv ====
// Datapath of the single-cycle core: pc, register file, immediates and ALU
// pc and the register file update on the rising clock edge only
// Register x0 reads as zero; the register file itself has no reset
`default_nettype none

module singlecycle_datapath (
  input  logic          clock,
  input  logic          rst,
  input  rv_pkg::xlen_t inst,
  input  rv_pkg::xlen_t data_mem_read_data,
  ctl_if.dp             ctl,
  output logic [6:0]    inst_opcode,
  output logic [2:0]    inst_funct3,
  output logic [6:0]    inst_funct7,
  output logic          alu_result_equal_zero,
  output rv_pkg::xlen_t data_mem_address,
  output rv_pkg::xlen_t data_mem_write_data,
  output rv_pkg::xlen_t pc
);

  rv_pkg::xlen_t regs [rv_pkg::NUM_REGS];
  logic [4:0]    rs1, rs2, rd;
  rv_pkg::xlen_t rs1_data, rs2_data;
  rv_pkg::xlen_t immediate;
  rv_pkg::xlen_t operand_a, operand_b, alu_result;
  rv_pkg::xlen_t pc_plus_4, next_pc, writeback_data;
  logic [4:0]    shamt;

  // --------------------------------------------------
  // Field split and register read
  assign inst_opcode = inst[6:0];
  assign inst_funct3 = inst[14:12];
  assign inst_funct7 = inst[31:25];
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  // Immediate format follows the opcode
  always_comb begin
    case (inst_opcode)
      rv_pkg::OP_IMM, rv_pkg::LOAD, rv_pkg::JALR:
        immediate = {{20{inst[31]}}, inst[31:20]};
      rv_pkg::STORE:
        immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      rv_pkg::BRANCH:
        immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      rv_pkg::LUI, rv_pkg::AUIPC:
        immediate = {inst[31:12], 12'b0};
      rv_pkg::JAL:
        immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        immediate = '0;
    endcase
  end

  // --------------------------------------------------
  // ALU
  assign operand_a = ctl.alu_operand_a_select ? pc : rs1_data;
  assign operand_b = ctl.alu_operand_b_select ? immediate : rs2_data;
  assign shamt = operand_b[4:0];

  always_comb begin
    case (ctl.alu_function)
      rv_pkg::ALU_ADD:    alu_result = operand_a + operand_b;
      rv_pkg::ALU_SUB:    alu_result = operand_a - operand_b;
      rv_pkg::ALU_SLL:    alu_result = operand_a << shamt;
      rv_pkg::ALU_SLT:    alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      rv_pkg::ALU_SLTU:   alu_result = {31'b0, operand_a < operand_b};
      rv_pkg::ALU_XOR:    alu_result = operand_a ^ operand_b;
      rv_pkg::ALU_SRL:    alu_result = operand_a >> shamt;
      rv_pkg::ALU_SRA:    alu_result = $unsigned($signed(operand_a) >>> shamt);
      rv_pkg::ALU_OR:     alu_result = operand_a | operand_b;
      rv_pkg::ALU_AND:    alu_result = operand_a & operand_b;
      rv_pkg::ALU_SEQ:    alu_result = {31'b0, operand_a == operand_b};
      rv_pkg::ALU_SNE:    alu_result = {31'b0, operand_a != operand_b};
      rv_pkg::ALU_SGE:    alu_result = {31'b0, $signed(operand_a) >= $signed(operand_b)};
      rv_pkg::ALU_SGEU:   alu_result = {31'b0, operand_a >= operand_b};
      rv_pkg::ALU_PASS_B: alu_result = operand_b;
      default:            alu_result = '0;
    endcase
  end

  assign alu_result_equal_zero = (alu_result == '0);
  assign data_mem_address      = alu_result;
  assign data_mem_write_data   = rs2_data;

  // --------------------------------------------------
  // Next pc and writeback
  assign pc_plus_4 = pc + 32'd4;

  always_comb begin
    case (ctl.next_pc_select)
      rv_pkg::NPC_PC_PLUS_IMM: next_pc = pc + immediate;
      rv_pkg::NPC_ALU_ALIGNED: next_pc = {alu_result[31:1], 1'b0};
      default:                 next_pc = pc_plus_4;
    endcase
  end

  always_comb begin
    case (ctl.reg_writeback_select)
      rv_pkg::WB_MEM:       writeback_data = data_mem_read_data;
      rv_pkg::WB_PC_PLUS_4: writeback_data = pc_plus_4;
      default:              writeback_data = alu_result;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= rv_pkg::RESET_PC;
    end else if (ctl.pc_write_enable) begin
      pc <= next_pc;
    end
  end

  // Writes to x0 are dropped
  always_ff @(posedge clock) begin
    if (ctl.regfile_write_enable && rd != 5'd0) begin
      regs[rd] <= writeback_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/data_memory_interface.sv ====
// Byte-lane bus adapter for loads and stores
// Misaligned accesses are not trapped and halfwords ignore address bit 0
// Bus read data must be valid in the same cycle as the request
`default_nettype none

module data_memory_interface (
  input  logic          read_enable,
  input  logic          write_enable,
  input  logic [2:0]    data_format,
  input  rv_pkg::xlen_t address,
  input  rv_pkg::xlen_t write_data,
  input  rv_pkg::xlen_t bus_read_data,
  output rv_pkg::xlen_t read_data,
  output rv_pkg::xlen_t bus_address,
  output rv_pkg::xlen_t bus_write_data,
  output logic [3:0]    bus_byte_enable,
  output logic          bus_read_enable,
  output logic          bus_write_enable
);

  rv_pkg::xlen_t lane_data;
  logic          is_unsigned;

  assign bus_address      = {address[31:2], 2'b00};
  assign bus_read_enable  = read_enable;
  assign bus_write_enable = write_enable;
  assign is_unsigned      = data_format[2];

  // --------------------------------------------------
  // Lane selection and store replication
  always_comb begin
    bus_byte_enable = 4'b0000;
    case (data_format[1:0])
      2'b00: bus_write_data = {4{write_data[7:0]}};
      2'b01: bus_write_data = {2{write_data[15:0]}};
      default: bus_write_data = write_data;
    endcase
    if (read_enable || write_enable) begin
      case (data_format[1:0])
        2'b00: bus_byte_enable = 4'b0001 << address[1:0];
        2'b01: bus_byte_enable = address[1] ? 4'b1100 : 4'b0011;
        default: bus_byte_enable = 4'b1111;
      endcase
    end
  end

  // Load data shifted down to lane 0, then extended
  assign lane_data = bus_read_data >> {address[1:0], 3'b000};

  always_comb begin
    case (data_format[1:0])
      2'b00: read_data = {{24{lane_data[7] & ~is_unsigned}}, lane_data[7:0]};
      2'b01: begin
        if (address[1]) begin
          read_data = {{16{bus_read_data[31] & ~is_unsigned}}, bus_read_data[31:16]};
        end else begin
          read_data = {{16{bus_read_data[15] & ~is_unsigned}}, bus_read_data[15:0]};
        end
      end
      default: read_data = bus_read_data;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/riscv_core.sv ====
// Single-cycle RV32I core top level
// inst must match pc in the same cycle; the bus answers in the same cycle
`default_nettype none

module riscv_core (
  input  logic          clock,
  input  logic          rst,
  input  rv_pkg::xlen_t inst,
  input  rv_pkg::xlen_t bus_read_data,
  output rv_pkg::xlen_t pc,
  output rv_pkg::xlen_t bus_address,
  output rv_pkg::xlen_t bus_write_data,
  output logic [3:0]    bus_byte_enable,
  output logic          bus_read_enable,
  output logic          bus_write_enable
);

  ctl_if ctl_bus ();

  logic [6:0]    inst_opcode;
  logic [2:0]    inst_funct3;
  logic [6:0]    inst_funct7;
  logic          alu_result_equal_zero;
  logic          data_mem_read_enable;
  logic          data_mem_write_enable;
  rv_pkg::xlen_t data_mem_address;
  rv_pkg::xlen_t data_mem_write_data;
  rv_pkg::xlen_t data_mem_read_data;

  singlecycle_ctlpath ctlpath (
    .rst                   (rst),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .ctl                   (ctl_bus.ctl),
    .data_mem_read_enable  (data_mem_read_enable),
    .data_mem_write_enable (data_mem_write_enable)
  );

  singlecycle_datapath datapath (
    .clock                 (clock),
    .rst                   (rst),
    .inst                  (inst),
    .data_mem_read_data    (data_mem_read_data),
    .ctl                   (ctl_bus.dp),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .pc                    (pc)
  );

  // funct3 doubles as the load/store format
  data_memory_interface dmem (
    .read_enable      (data_mem_read_enable),
    .write_enable     (data_mem_write_enable),
    .data_format      (inst_funct3),
    .address          (data_mem_address),
    .write_data       (data_mem_write_data),
    .bus_read_data    (bus_read_data),
    .read_data        (data_mem_read_data),
    .bus_address      (bus_address),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );

endmodule

`default_nettype wire

// ==== testbench/riscv_core_assert.sv ====
// Concurrent checks on the core's bus enables and pc, bound into riscv_core
// pc alignment is only checked outside reset
`default_nettype none

module riscv_core_assert (
  input logic          clock,
  input logic          rst,
  input rv_pkg::xlen_t pc,
  input logic [3:0]    bus_byte_enable,
  input logic          bus_read_enable,
  input logic          bus_write_enable
);

  enables_exclusive: assert property (
    @(posedge clock) !(bus_read_enable && bus_write_enable)
  ) else $error("bus read and write enables are high in the same cycle");

  // No lanes without an access
  idle_lanes: assert property (
    @(posedge clock) (!bus_read_enable && !bus_write_enable) |-> (bus_byte_enable == 4'b0000)
  ) else $error("byte enables active with no bus access");

  pc_aligned: assert property (
    @(posedge clock) disable iff (rst) (pc[1:0] == 2'b00)
  ) else $error("pc is not word aligned");

endmodule

bind riscv_core riscv_core_assert core_checks (
  .clock            (clock),
  .rst              (rst),
  .pc               (pc),
  .bus_byte_enable  (bus_byte_enable),
  .bus_read_enable  (bus_read_enable),
  .bus_write_enable (bus_write_enable)
);

`default_nettype wire

// ==== testbench/riscv_core_tb.sv ====
// Testbench for the single-cycle RV32I core
// Random legal instructions are checked against an instruction-level model
// All registers are loaded with known values before the random tests run
`default_nettype none

module riscv_core_tb;

  localparam int RESET_CYCLES = 5;
  localparam int INIT_COUNT   = 62;
  localparam int ALU_COUNT    = 400;
  localparam int LOAD_COUNT   = 300;
  localparam int STORE_COUNT  = 300;
  localparam int CTRL_COUNT   = 500;
  localparam int X0_COUNT     = 40;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + INIT_COUNT + ALU_COUNT + LOAD_COUNT
                                + STORE_COUNT + CTRL_COUNT + X0_COUNT + 900;

  logic          clock;
  logic          rst;
  rv_pkg::xlen_t inst;
  rv_pkg::xlen_t bus_read_data;
  rv_pkg::xlen_t pc;
  rv_pkg::xlen_t bus_address;
  rv_pkg::xlen_t bus_write_data;
  logic [3:0]    bus_byte_enable;
  logic          bus_read_enable;
  logic          bus_write_enable;

  // Model state and the fields of the next instruction
  rv_pkg::xlen_t   model_regs [32];
  rv_pkg::xlen_t   model_pc;
  rv_pkg::opcode_t op;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic [4:0]      rd, rs1, rs2;
  rv_pkg::xlen_t   imm;
  rv_pkg::xlen_t   rand_word;

  int check_count, error_count, test_count, cycle_count;
  int test_checks_start, test_errors_start;

  riscv_core dut (
    .clock            (clock),
    .rst              (rst),
    .inst             (inst),
    .bus_read_data    (bus_read_data),
    .pc               (pc),
    .bus_address      (bus_address),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles before the tests finished", cycle_count);
    $display("Test failed");
    $finish;
  end

  // --------------------------------------------------
  // Helpers
  task automatic check_value(input string name, input rv_pkg::xlen_t expected,
                             input rv_pkg::xlen_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic start_test();
    test_checks_start = check_count;
    test_errors_start = error_count;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("%s done: %0d checks, %0d errors", name, check_count - test_checks_start,
             error_count - test_errors_start);
  endtask

  function automatic rv_pkg::xlen_t sext(input rv_pkg::xlen_t value, input int bits);
    return rv_pkg::xlen_t'($signed(value << (32 - bits)) >>> (32 - bits));
  endfunction

  // Standard RV32I instruction formats
  function automatic rv_pkg::xlen_t encode();
    case (op)
      rv_pkg::OP:     return {f7, rs2, rs1, f3, rd, op};
      rv_pkg::STORE:  return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
      rv_pkg::BRANCH: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
      rv_pkg::LUI, rv_pkg::AUIPC: return {imm[31:12], rd, op};
      rv_pkg::JAL:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
      default:        return {imm[11:0], rs1, f3, rd, op};
    endcase
  endfunction

  function automatic rv_pkg::xlen_t alu_model(input logic [2:0] fn, input logic alt,
                                              input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
    case (fn)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? rv_pkg::xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] fn, input rv_pkg::xlen_t a,
                                        input rv_pkg::xlen_t b);
    case (fn)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // A lane is enabled when it lies inside the naturally aligned access
  function automatic logic [3:0] lane_enables(input logic [1:0] size, input logic [1:0] offset);
    int         bytes;
    int         first;
    logic [3:0] lanes;
    bytes = 1 << size;
    first = int'(offset) / bytes * bytes;
    for (int i = 0; i < 4; i++) begin
      lanes[i] = (i >= first) && (i < first + bytes);
    end
    return lanes;
  endfunction

  // Each lane carries the store byte at its position within the access size
  function automatic rv_pkg::xlen_t replicate_store(input logic [1:0] size,
                                                    input rv_pkg::xlen_t data);
    int            bytes;
    rv_pkg::xlen_t lanes;
    bytes = 1 << size;
    for (int i = 0; i < 4; i++) begin
      lanes[8*i +: 8] = data[8*(i % bytes) +: 8];
    end
    return lanes;
  endfunction

  function automatic rv_pkg::xlen_t load_value(input logic [2:0] fn, input logic [1:0] offset,
                                               input rv_pkg::xlen_t data);
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    byte_lane = data[8*offset +: 8];
    half_lane = offset[1] ? data[31:16] : data[15:0];
    case (fn)
      3'd0: return sext({24'b0, byte_lane}, 8);
      3'd1: return sext({16'b0, half_lane}, 16);
      3'd4: return {24'b0, byte_lane};
      3'd5: return {16'b0, half_lane};
      default: return data;
    endcase
  endfunction

  // --------------------------------------------------
  // Drive one instruction, compare with the model, then advance the model
  task automatic execute_and_check();
    rv_pkg::xlen_t a, b, addr, result, next_pc;
    logic          write_rd, exp_read, exp_write;
    logic [3:0]    exp_lanes;
    @(negedge clock);
    inst = encode();
    bus_read_data = $urandom;
    #5;
    a = model_regs[rs1];
    b = model_regs[rs2];
    addr = a + imm;
    result = '0;
    next_pc = model_pc + 32'd4;
    write_rd = 1'b1;
    exp_read = 1'b0;
    exp_write = 1'b0;
    case (op)
      rv_pkg::OP:     result = alu_model(f3, f7[5], a, b);
      rv_pkg::OP_IMM: result = alu_model(f3, (f3 == 3'd5) && imm[10], a, imm);
      rv_pkg::LUI:    result = imm;
      rv_pkg::AUIPC:  result = model_pc + imm;
      rv_pkg::LOAD: begin
        exp_read = 1'b1;
        result = load_value(f3, addr[1:0], bus_read_data);
      end
      rv_pkg::STORE: begin
        exp_write = 1'b1;
        write_rd = 1'b0;
      end
      rv_pkg::BRANCH: begin
        write_rd = 1'b0;
        if (branch_taken(f3, a, b)) begin
          next_pc = model_pc + imm;
        end
      end
      rv_pkg::JAL: begin
        result = model_pc + 32'd4;
        next_pc = model_pc + imm;
      end
      rv_pkg::JALR: begin
        result = model_pc + 32'd4;
        next_pc = addr & ~32'd1;
      end
      default: write_rd = 1'b0;
    endcase
    exp_lanes = (exp_read || exp_write) ? lane_enables(f3[1:0], addr[1:0]) : 4'b0000;

    check_value("pc", model_pc, pc);
    check_value("bus_read_enable", 32'(exp_read), 32'(bus_read_enable));
    check_value("bus_write_enable", 32'(exp_write), 32'(bus_write_enable));
    check_value("bus_byte_enable", 32'(exp_lanes), 32'(bus_byte_enable));
    if (exp_read || exp_write) begin
      check_value("bus_address", addr & 32'hffff_fffc, bus_address);
    end
    if (exp_write) begin
      check_value("bus_write_data", replicate_store(f3[1:0], b), bus_write_data);
    end

    if (write_rd && rd != 5'd0) begin
      model_regs[rd] = result;
    end
    model_pc = next_pc;
  endtask

  // --------------------------------------------------
  // Random instruction pickers
  task automatic random_fields();
    rd  = 5'($urandom_range(31, 1));
    rs1 = 5'($urandom_range(31, 0));
    rs2 = 5'($urandom_range(31, 0));
    f3  = 3'($urandom_range(7, 0));
    f7  = 7'b0;
    imm = sext($urandom, 12);
  endtask

  task automatic pick_alu();
    random_fields();
    case ($urandom_range(3, 0))
      0: begin
        op = rv_pkg::OP;
        if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) != 0) begin
          f7 = 7'b0100000;
        end
      end
      1: begin
        op = rv_pkg::OP_IMM;
        // Shift immediates carry only shamt and the arithmetic bit
        if (f3 == 3'd1) begin
          imm = imm & 32'h1f;
        end else if (f3 == 3'd5) begin
          imm = (imm & 32'h1f) | ($urandom_range(1, 0) << 10);
        end
      end
      2: begin
        op = rv_pkg::LUI;
        imm = $urandom & 32'hffff_f000;
      end
      default: begin
        op = rv_pkg::AUIPC;
        imm = $urandom & 32'hffff_f000;
      end
    endcase
  endtask

  task automatic pick_load();
    random_fields();
    op = rv_pkg::LOAD;
    do f3 = 3'($urandom_range(5, 0)); while (f3 == 3'd3);
  endtask

  task automatic pick_store();
    random_fields();
    op = rv_pkg::STORE;
    f3 = 3'($urandom_range(2, 0));
  endtask

  // Targets keep pc word aligned
  task automatic pick_control();
    random_fields();
    case ($urandom_range(2, 0))
      0: begin
        op = rv_pkg::BRANCH;
        do f3 = 3'($urandom_range(7, 0)); while (f3 == 3'd2 || f3 == 3'd3);
        if ($urandom_range(3, 0) == 0) begin
          rs2 = rs1;
        end
        imm = sext($urandom & 32'h1ffc, 13);
      end
      1: begin
        op = rv_pkg::JAL;
        imm = sext($urandom & 32'h1f_fffc, 21);
      end
      default: begin
        op = rv_pkg::JALR;
        f3 = 3'd0;
        if (((model_regs[rs1] + imm) & 32'd2) != 0) begin
          imm = imm ^ 32'd2;
        end
      end
    endcase
  endtask

  // sw of the last destination exposes its value on the bus
  task automatic store_back();
    rs2 = rd;
    rs1 = 5'($urandom_range(31, 0));
    op  = rv_pkg::STORE;
    f3  = 3'd2;
    imm = sext($urandom, 12);
    execute_and_check();
  endtask

  // --------------------------------------------------
  initial begin
    rst = 1'b1;
    inst = '0;
    bus_read_data = '0;
    check_count = 0;
    error_count = 0;
    test_count = 0;
    rand_word = $urandom(32'h6cb9_ee24);
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    model_pc = rv_pkg::RESET_PC;

    start_test();
    repeat (RESET_CYCLES - 1) begin
      @(negedge clock);
      rand_word = $urandom;
      inst = {rand_word[31:7], rand_word[0] ? rv_pkg::LOAD : rv_pkg::STORE};
      #5;
      check_value("pc", rv_pkg::RESET_PC, pc);
      check_value("bus_read_enable", 32'h0, 32'(bus_read_enable));
      check_value("bus_write_enable", 32'h0, 32'(bus_write_enable));
    end
    @(negedge clock);
    rst = 1'b0;
    // Opcode zero is not decoded and runs as a no-op
    inst = '0;
    #5;
    check_value("pc", rv_pkg::RESET_PC, pc);
    model_pc = rv_pkg::RESET_PC + 32'd4;
    end_test("reset");

    start_test();
    for (int r = 1; r < 32; r++) begin
      op = rv_pkg::LUI;
      rd = 5'(r);
      imm = $urandom & 32'hffff_f000;
      execute_and_check();
      op = rv_pkg::OP_IMM;
      f3 = 3'd0;
      rs1 = 5'(r);
      imm = sext($urandom, 12);
      execute_and_check();
    end
    end_test("register init");

    start_test();
    repeat (ALU_COUNT / 2) begin
      pick_alu();
      execute_and_check();
      store_back();
    end
    end_test("alu and immediates");

    start_test();
    repeat (LOAD_COUNT / 2) begin
      pick_load();
      execute_and_check();
      store_back();
    end
    end_test("loads");

    start_test();
    repeat (STORE_COUNT) begin
      pick_store();
      execute_and_check();
    end
    end_test("stores");

    start_test();
    repeat (CTRL_COUNT / 2) begin
      pick_control();
      execute_and_check();
      store_back();
    end
    end_test("control flow");

    start_test();
    repeat (X0_COUNT / 2) begin
      if ($urandom_range(1, 0) != 0) begin
        pick_alu();
      end else begin
        pick_load();
      end
      rd = 5'd0;
      execute_and_check();
      store_back();
      check_value("bus_write_data", 32'h0, bus_write_data);
    end
    @(negedge clock);
    check_value("pc", model_pc, pc);
    end_test("x0");

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/rv_pkg.sv
design/ctl_if.sv
design/singlecycle_ctlpath.sv
design/singlecycle_datapath.sv
design/data_memory_interface.sv
design/riscv_core.sv
testbench/riscv_core_assert.sv
testbench/riscv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= riscv_core_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; \
	elif grep -q "Test passed" $(LOG); then echo "PASS"; \
	else echo "FAIL: no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
